// File: hw/lpif_auto_sync.sv
/*
  Link auto-sync
  Holds off tx and rx after an online request by programmable delays,
  then enables strobe insertion after a further delay. Marker and
  strobe user bits are driven persistently while enabled
*/

`timescale 1ns/1ns

module lpif_auto_sync import lpif_pkg::*; (
  input  logic    clk_wr,
  input  logic    rst,

  // Online requests
  input  logic    tx_online,
  input  logic    rx_online,

  // Delay configuration
  input  delay_t  delay_x_value,
  input  delay_t  delay_y_value,
  input  delay_t  delay_z_value,

  // Configured user bits
  input  marker_t tx_mrk_userbit,
  input  logic    tx_stb_userbit,

  lpif_link_if.sync link
);

  // One counter lane per delayed level
  localparam int N_LANE  = 3;
  localparam int LN_RX   = 0;
  localparam int LN_TX   = 1;
  localparam int LN_STB  = 2;

  logic [N_LANE-1:0]   lane_in;
  delay_t [N_LANE-1:0] lane_dly;
  delay_t [N_LANE-1:0] cnt_q;
  logic [N_LANE-1:0]   lvl_q;

  //////////////////////////////////////////////////
  // Lane inputs

  always_comb begin
    // rx uses delay x, tx uses delay y
    lane_in[LN_RX]   = rx_online;
    lane_dly[LN_RX]  = delay_x_value;
    lane_in[LN_TX]   = tx_online;
    lane_dly[LN_TX]  = delay_y_value;
    // Strobe timer runs behind delayed tx and drops with tx_online
    lane_in[LN_STB]  = tx_online & lvl_q[LN_TX];
    lane_dly[LN_STB] = delay_z_value;
  end

  //////////////////////////////////////////////////
  // Delay counters

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      cnt_q <= '0;
      lvl_q <= '0;
    end else begin
      for (int i = 0; i < N_LANE; i++) begin
        if (!lane_in[i]) begin
          // Input dropped, restart
          cnt_q[i] <= '0;
          lvl_q[i] <= 1'b0;
        end else if (cnt_q[i] >= lane_dly[i]) begin
          // Saturated, level goes up next cycle
          lvl_q[i] <= 1'b1;
        end else begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Link outputs

  assign link.tx_online_delay = lvl_q[LN_TX];
  assign link.rx_online_delay = lvl_q[LN_RX];

  // Persistent strobe once the z timer expires
  assign link.auto_stb = lvl_q[LN_STB] & tx_stb_userbit;
  // Markers follow delayed tx online
  assign link.auto_mrk = lvl_q[LN_TX] ? tx_mrk_userbit : '0;

endmodule

// File: hw/lpif_flit_pack.sv
/*
  Flit pack and unpack
  Packs the downstream user fields into one tx flit and splits the
  received flit into upstream fields. CRC is suppressed in gen1 mode
*/

`timescale 1ns/1ns

module lpif_flit_pack import lpif_pkg::*; #(
  parameter  int DATA_W = 64,
  localparam int FLIT_W = DATA_W + FIXED_FLIT_W
) (
  // Gen2 carries CRC, gen1 does not
  input  logic              m_gen2_mode,

  // Downstream channel
  input  state_t            dstrm_state,
  input  protid_t           dstrm_protid,
  input  logic [DATA_W-1:0] dstrm_data,
  input  logic              dstrm_dvalid,
  input  crc_t              dstrm_crc,
  input  logic              dstrm_crc_valid,
  input  logic              dstrm_valid,

  // Flits to and from the PHY block
  output logic [FLIT_W-1:0] tx_flit,
  input  logic [FLIT_W-1:0] rx_flit,

  // Upstream channel
  output state_t            ustrm_state,
  output protid_t           ustrm_protid,
  output logic [DATA_W-1:0] ustrm_data,
  output logic              ustrm_dvalid,
  output crc_t              ustrm_crc,
  output logic              ustrm_crc_valid,
  output logic              ustrm_valid
);

  crc_t rx_crc;
  logic rx_crc_valid;

  //////////////////////////////////////////////////
  // Transmit packing

  // LSB first: valid, crc_valid, crc, dvalid, data, protid, state
  // Top bit is spare and always zero
  assign tx_flit = {1'b0, dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                    m_gen2_mode ? dstrm_crc : crc_t'(0),
                    m_gen2_mode & dstrm_crc_valid,
                    dstrm_valid};

  //////////////////////////////////////////////////
  // Receive unpacking

  assign {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
          rx_crc, rx_crc_valid, ustrm_valid} = rx_flit[FLIT_W-2:0];

  // No CRC upstream in gen1
  assign ustrm_crc       = m_gen2_mode ? rx_crc : crc_t'(0);
  assign ustrm_crc_valid = m_gen2_mode & rx_crc_valid;

endmodule

// File: hw/lpif_link_if.sv
/*
  Link control interface
  Delayed online levels and the automatic strobe and marker user bits,
  driven by the auto-sync block and consumed by the PHY block
*/

`timescale 1ns/1ns

interface lpif_link_if import lpif_pkg::*; ();

  // Online levels after the sync delays
  logic    tx_online_delay;
  logic    rx_online_delay;

  // Gated user bits for the PHY words
  marker_t auto_mrk;
  logic    auto_stb;

  // Sync side drives everything
  modport sync (
    output tx_online_delay,
    output rx_online_delay,
    output auto_mrk,
    output auto_stb
  );

  // PHY side only listens
  modport phy (
    input tx_online_delay,
    input rx_online_delay,
    input auto_mrk,
    input auto_stb
  );

endinterface

// File: hw/lpif_link_top.sv
/*
  LPIF link top
  Auto-sync, flit pack and PHY concat tied together behind plain ports
*/

`timescale 1ns/1ns

module lpif_link_top import lpif_pkg::*; #(
  parameter  int DATA_W = 64,
  localparam int FLIT_W = DATA_W + FIXED_FLIT_W,
  localparam int PHY_W  = FLIT_W / 2 + PAYLOAD_POS
) (
  input  logic              clk_wr,
  input  logic              rst,

  // Online requests
  input  logic              tx_online,
  input  logic              rx_online,

  // PHY channels
  output logic [PHY_W-1:0]  tx_phy0,
  input  logic [PHY_W-1:0]  rx_phy0,
  output logic [PHY_W-1:0]  tx_phy1,
  input  logic [PHY_W-1:0]  rx_phy1,

  // Downstream channel
  input  state_t            dstrm_state,
  input  protid_t           dstrm_protid,
  input  logic [DATA_W-1:0] dstrm_data,
  input  logic              dstrm_dvalid,
  input  crc_t              dstrm_crc,
  input  logic              dstrm_crc_valid,
  input  logic              dstrm_valid,

  // Upstream channel
  output state_t            ustrm_state,
  output protid_t           ustrm_protid,
  output logic [DATA_W-1:0] ustrm_data,
  output logic              ustrm_dvalid,
  output crc_t              ustrm_crc,
  output logic              ustrm_crc_valid,
  output logic              ustrm_valid,

  output logic [31:0]       debug_status,

  // Configuration
  input  logic              m_gen2_mode,
  input  marker_t           tx_mrk_userbit,
  input  logic              tx_stb_userbit,
  input  delay_t            delay_x_value,
  input  delay_t            delay_y_value,
  input  delay_t            delay_z_value
);

  logic [FLIT_W-1:0] tx_flit;
  logic [FLIT_W-1:0] rx_flit;

  // Sync to PHY control
  lpif_link_if link_i ();

  //////////////////////////////////////////////////
  // Auto sync

  lpif_auto_sync auto_sync_i (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .link           (link_i)
  );

  //////////////////////////////////////////////////
  // User side and PHY side

  lpif_flit_pack #(.DATA_W(DATA_W)) flit_pack_i (
    .m_gen2_mode     (m_gen2_mode),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  lpif_phy_concat #(.DATA_W(DATA_W)) phy_concat_i (
    .clk_wr       (clk_wr),
    .rst          (rst),
    .link         (link_i),
    .tx_flit      (tx_flit),
    .rx_flit      (rx_flit),
    .tx_phy0      (tx_phy0),
    .tx_phy1      (tx_phy1),
    .rx_phy0      (rx_phy0),
    .rx_phy1      (rx_phy1),
    .debug_status (debug_status)
  );

endmodule

// File: hw/lpif_phy_concat.sv
/*
  PHY concat
  Splits the tx flit over two registered PHY words with strobe and
  marker bits, reassembles the rx flit from two PHY words and keeps
  a small debug status with a received strobe count
*/

`timescale 1ns/1ns

module lpif_phy_concat import lpif_pkg::*; #(
  parameter  int DATA_W = 64,
  localparam int FLIT_W = DATA_W + FIXED_FLIT_W,
  localparam int HALF_W = FLIT_W / 2,
  localparam int PHY_W  = HALF_W + PAYLOAD_POS
) (
  input  logic              clk_wr,
  input  logic              rst,

  lpif_link_if.phy          link,

  // Flits from and to the pack block
  input  logic [FLIT_W-1:0] tx_flit,
  output logic [FLIT_W-1:0] rx_flit,

  // PHY channels
  output logic [PHY_W-1:0]  tx_phy0,
  output logic [PHY_W-1:0]  tx_phy1,
  input  logic [PHY_W-1:0]  rx_phy0,
  input  logic [PHY_W-1:0]  rx_phy1,

  output logic [31:0]       debug_status
);

  // Markers carried by each channel
  localparam int MRK_CH_W = MARKER_W / 2;

  logic        tx_lvl_q;
  logic        rx_lvl_q;
  logic [15:0] stb_cnt_q;

  // One PHY word from a flit half and its user bits
  function automatic logic [PHY_W-1:0] build_word(
    input logic [HALF_W-1:0]   half,
    input logic [MRK_CH_W-1:0] mrk,
    input logic                stb
  );
    logic [PHY_W-1:0] w;
    w = '0;
    w[STB_POS]                = stb;
    w[MRK_POS +: MRK_CH_W]    = mrk;
    w[PAYLOAD_POS +: HALF_W]  = half;
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Transmit

  always_ff @(posedge clk_wr) begin
    if (rst || !link.tx_online_delay) begin
      // Idle words while tx is held off
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      // Lower half and markers 1:0 on channel 0
      tx_phy0 <= build_word(tx_flit[0 +: HALF_W],
                            link.auto_mrk[0 +: MRK_CH_W], link.auto_stb);
      // Upper half and markers 3:2 on channel 1
      tx_phy1 <= build_word(tx_flit[HALF_W +: HALF_W],
                            link.auto_mrk[MRK_CH_W +: MRK_CH_W], link.auto_stb);
    end
  end

  //////////////////////////////////////////////////
  // Receive

  always_ff @(posedge clk_wr) begin
    if (rst || !link.rx_online_delay) begin
      rx_flit <= '0;
    end else begin
      // Drop user bits, keep the payload halves
      rx_flit <= {rx_phy1[PAYLOAD_POS +: HALF_W], rx_phy0[PAYLOAD_POS +: HALF_W]};
    end
  end

  //////////////////////////////////////////////////
  // Debug status

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_lvl_q  <= 1'b0;
      rx_lvl_q  <= 1'b0;
      stb_cnt_q <= '0;
    end else begin
      tx_lvl_q <= link.tx_online_delay;
      rx_lvl_q <= link.rx_online_delay;
      // Count received strobes, hold at max
      if (link.rx_online_delay && rx_phy0[STB_POS] && (stb_cnt_q != 16'hffff)) begin
        stb_cnt_q <= stb_cnt_q + 16'd1;
      end
    end
  end

  // Bit 19 tx level, bit 18 rx level, 15:0 strobe count
  assign debug_status = {12'h000, tx_lvl_q, rx_lvl_q, 2'b00, stb_cnt_q};

endmodule

// File: hw/lpif_pkg.sv
/*
  LPIF link layer shared definitions
  Field types of the user channel, marker width and the fixed bit
  positions of strobe, marker and payload in each PHY channel word
*/

package lpif_pkg;

  //////////////////////////////////////////////////
  // User channel field types

  // Link state field
  typedef logic [3:0] state_t;
  // Protocol id
  typedef logic [7:0] protid_t;
  // CRC field of the flit
  typedef logic [15:0] crc_t;
  // Programmable delays of the sync counters
  typedef logic [15:0] delay_t;

  //////////////////////////////////////////////////
  // PHY word layout

  // Marker user bits over both channels, half per channel
  localparam int MARKER_W = 4;
  typedef logic [MARKER_W-1:0] marker_t;

  // Strobe in bit 0 of every PHY word
  localparam int STB_POS = 0;
  // Markers right above the strobe
  localparam int MRK_POS = 1;
  // Payload half starts after the per-channel markers
  localparam int PAYLOAD_POS = MRK_POS + MARKER_W / 2;

  // Non-data flit bits
  // 31 field bits (state, protid, dvalid, crc, crc_valid, valid)
  // plus one spare MSB so that the flit splits evenly
  localparam int FIXED_FLIT_W = 32;

endpackage

// File: run.sh
#!/bin/sh
# Build the LPIF link testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --assert -Wno-fatal --top-module tb_lpif_link -f verilog.f &&
  ./obj_dir/Vtb_lpif_link | tee /dev/stderr | grep -qx "TEST OK" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// File: tb/lpif_link_chk.sv
/*
  PHY concat checker
  Concurrent assertions on tx idle words, strobe gating and the
  online levels in the debug status
*/

`timescale 1ns/1ns

module lpif_link_chk import lpif_pkg::*; #(
  parameter int PHY_W = 51
) (
  input logic             clk_wr,
  input logic             rst,
  input logic             tx_online_delay,
  input logic             rx_online_delay,
  input logic             auto_stb,
  input logic [PHY_W-1:0] tx_phy0,
  input logic [PHY_W-1:0] tx_phy1,
  input logic [31:0]      debug_status
);

  // Held-off tx gives idle words one cycle later
  tx_idle_a: assert property (@(posedge clk_wr) disable iff (rst)
    !tx_online_delay |=> (tx_phy0 == '0) && (tx_phy1 == '0))
    else $error("tx PHY words not idle after tx_online_delay was low");

  // auto_stb is the gated tx_stb_userbit
  tx_stb_a: assert property (@(posedge clk_wr) disable iff (rst)
    !auto_stb |=> !tx_phy0[STB_POS] && !tx_phy1[STB_POS])
    else $error("tx strobe bit set without a strobe user bit");

  // Status levels lag the link by one register
  status_lvl_a: assert property (@(posedge clk_wr) disable iff (rst)
    debug_status[19:18] == $past({tx_online_delay, rx_online_delay}))
    else $error("debug_status online bits do not follow the link levels");

endmodule

bind lpif_phy_concat lpif_link_chk #(.PHY_W(PHY_W)) link_chk_i (
  .clk_wr          (clk_wr),
  .rst             (rst),
  .tx_online_delay (link.tx_online_delay),
  .rx_online_delay (link.rx_online_delay),
  .auto_stb        (link.auto_stb),
  .tx_phy0         (tx_phy0),
  .tx_phy1         (tx_phy1),
  .debug_status    (debug_status)
);

// File: tb/tb_lpif_link.sv
/*
  LPIF link testbench
  Directed tests on reset, sync delays, loopback in both modes,
  user bits and offline gating. Expected values come from a queue
  that lags the driven fields by the two-cycle loopback
*/

`timescale 1ns/1ns

module tb_lpif_link import lpif_pkg::*; ();

  localparam int DATA_W      = 64;
  localparam int FLIT_W      = DATA_W + FIXED_FLIT_W;
  localparam int PHY_W       = FLIT_W / 2 + PAYLOAD_POS;
  // Tests run about 500 cycles
  localparam int CYCLE_LIMIT = 2000;

  // One set of user channel fields
  typedef struct packed {
    state_t            state;
    protid_t           protid;
    logic [DATA_W-1:0] data;
    logic              dvalid;
    crc_t              crc;
    logic              crc_valid;
    logic              valid;
  } fields_t;

  logic              clk_wr;
  logic              rst;
  logic              tx_online;
  logic              rx_online;
  logic [PHY_W-1:0]  tx_phy0;
  logic [PHY_W-1:0]  rx_phy0;
  logic [PHY_W-1:0]  tx_phy1;
  logic [PHY_W-1:0]  rx_phy1;
  state_t            dstrm_state;
  protid_t           dstrm_protid;
  logic [DATA_W-1:0] dstrm_data;
  logic              dstrm_dvalid;
  crc_t              dstrm_crc;
  logic              dstrm_crc_valid;
  logic              dstrm_valid;
  state_t            ustrm_state;
  protid_t           ustrm_protid;
  logic [DATA_W-1:0] ustrm_data;
  logic              ustrm_dvalid;
  crc_t              ustrm_crc;
  logic              ustrm_crc_valid;
  logic              ustrm_valid;
  logic [31:0]       debug_status;
  logic              m_gen2_mode;
  marker_t           tx_mrk_userbit;
  logic              tx_stb_userbit;
  delay_t            delay_x_value;
  delay_t            delay_y_value;
  delay_t            delay_z_value;

  int     errors;
  int     cycle_cnt;
  integer seed;
  logic   loopback_en;

  lpif_link_top #(.DATA_W(DATA_W)) dut_i (.*);

  //////////////////////////////////////////////////
  // Clock and watchdog

  initial begin
    clk_wr = 1'b0;
    forever #4 clk_wr = ~clk_wr;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_wr);
      cycle_cnt++;
    end
    $display("Timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Helpers

  task automatic check_value(input string name, input logic [127:0] exp_val,
                             input logic [127:0] act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, exp_val, act_val);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("Failure at %0t ns: %s", $time, msg);
  endtask

  // Falling edge then tx words looped back onto rx
  task automatic next_cycle();
    @(negedge clk_wr);
    if (loopback_en) begin
      rx_phy0 = tx_phy0;
      rx_phy1 = tx_phy1;
    end
  endtask

  task automatic apply_fields(input fields_t f);
    dstrm_state     = f.state;
    dstrm_protid    = f.protid;
    dstrm_data      = f.data;
    dstrm_dvalid    = f.dvalid;
    dstrm_crc       = f.crc;
    dstrm_crc_valid = f.crc_valid;
    dstrm_valid     = f.valid;
  endtask

  task automatic random_fields(output fields_t f);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    f.state     = r0[3:0];
    f.protid    = r0[11:4];
    f.crc       = r0[27:12];
    f.dvalid    = r0[28];
    f.crc_valid = r0[29];
    f.valid     = r0[30];
    f.data      = {r1, r2};
  endtask

  task automatic compare_upstream(input fields_t e);
    check_value("ustrm_state", e.state, ustrm_state);
    check_value("ustrm_protid", e.protid, ustrm_protid);
    check_value("ustrm_data", e.data, ustrm_data);
    check_value("ustrm_dvalid", e.dvalid, ustrm_dvalid);
    check_value("ustrm_crc", e.crc, ustrm_crc);
    check_value("ustrm_crc_valid", e.crc_valid, ustrm_crc_valid);
    check_value("ustrm_valid", e.valid, ustrm_valid);
  endtask

  // Random flits through the loopback checked two cycles later
  task automatic run_loopback(input logic gen2, input int count);
    fields_t exp_q[$];
    fields_t f;
    fields_t e;
    m_gen2_mode = gen2;
    loopback_en = 1'b1;
    for (int i = 0; i < count + 2; i++) begin
      if (i >= 2) begin
        e = exp_q.pop_front();
        compare_upstream(e);
      end
      if (i < count) begin
        random_fields(f);
        apply_fields(f);
        // Gen1 carries no CRC
        if (!gen2) begin
          f.crc       = '0;
          f.crc_valid = 1'b0;
        end
        exp_q.push_back(f);
      end
      next_cycle();
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset_idle();
    fields_t f;
    // Busy inputs while both sides are offline
    random_fields(f);
    apply_fields(f);
    rx_phy0 = {PHY_W{1'b1}};
    rx_phy1 = {PHY_W{1'b1}};
    repeat (4) begin
      next_cycle();
      check_value("tx_phy0", '0, tx_phy0);
      check_value("tx_phy1", '0, tx_phy1);
      compare_upstream('0);
      check_value("debug_status", '0, debug_status);
    end
  endtask

  task automatic test_sync_delays();
    int t;
    int t_rx;
    int t_tx;
    int t_stb;
    delay_x_value  = 16'd3;
    delay_y_value  = 16'd5;
    delay_z_value  = 16'd4;
    tx_stb_userbit = 1'b1;
    loopback_en    = 1'b1;
    tx_online      = 1'b1;
    rx_online      = 1'b1;
    t     = 0;
    t_rx  = 0;
    t_tx  = 0;
    t_stb = 0;
    while (t < 40 && t_stb == 0) begin
      next_cycle();
      t++;
      if (t_rx == 0 && debug_status[18]) begin
        t_rx = t;
      end
      if (t_tx == 0 && debug_status[19]) begin
        t_tx = t;
      end
      if (tx_phy0[STB_POS]) begin
        t_stb = t;
      end
    end
    // Delay plus one for the counter and one for the status register
    if (t_rx == 0) begin
      note_failure("rx online status bit never rose");
    end else begin
      check_value("rx online status cycles", int'(delay_x_value) + 2, t_rx);
    end
    if (t_tx == 0) begin
      note_failure("tx online status bit never rose");
    end else begin
      check_value("tx online status cycles", int'(delay_y_value) + 2, t_tx);
    end
    // Strobe timer starts one cycle behind delayed tx, plus the word register
    if (t_stb == 0) begin
      note_failure("tx strobe bit never appeared");
    end else begin
      check_value("tx strobe cycles", int'(delay_y_value) + int'(delay_z_value) + 3, t_stb);
    end
  endtask

  task automatic test_loopback_gen2();
    run_loopback(1'b1, 200);
  endtask

  task automatic test_gen1_crc();
    run_loopback(1'b0, 200);
    // Rx words with every CRC bit set straight from the PHY side
    loopback_en = 1'b0;
    rx_phy0 = {PHY_W{1'b1}};
    rx_phy1 = {PHY_W{1'b1}};
    next_cycle();
    next_cycle();
    check_value("ustrm_valid", 1'b1, ustrm_valid);
    check_value("ustrm_crc", '0, ustrm_crc);
    check_value("ustrm_crc_valid", 1'b0, ustrm_crc_valid);
  endtask

  task automatic test_userbits_count();
    marker_t     mrk;
    logic [15:0] cnt_prev;
    logic        stb_prev;
    mrk            = 4'b1001;
    tx_mrk_userbit = mrk;
    tx_stb_userbit = 1'b1;
    loopback_en    = 1'b1;
    next_cycle();
    next_cycle();
    cnt_prev = debug_status[15:0];
    stb_prev = rx_phy0[STB_POS];
    repeat (32) begin
      next_cycle();
      check_value("looped strobe", 1'b1, stb_prev);
      check_value("debug_status[15:0]", cnt_prev + {15'd0, stb_prev}, debug_status[15:0]);
      check_value("tx_phy0 strobe", 1'b1, tx_phy0[STB_POS]);
      check_value("tx_phy1 strobe", 1'b1, tx_phy1[STB_POS]);
      // Channel 0 takes markers 1:0 and channel 1 takes 3:2
      check_value("tx_phy0 markers", mrk[1:0], tx_phy0[MRK_POS +: 2]);
      check_value("tx_phy1 markers", mrk[3:2], tx_phy1[MRK_POS +: 2]);
      cnt_prev = debug_status[15:0];
      stb_prev = rx_phy0[STB_POS];
    end
  endtask

  task automatic test_offline();
    tx_online = 1'b0;
    next_cycle();
    next_cycle();
    check_value("tx_phy0", '0, tx_phy0);
    check_value("tx_phy1", '0, tx_phy1);
    // Live rx words instead of the loopback
    loopback_en = 1'b0;
    rx_phy0 = {48'hc3c3_5a5a_0f0f, 3'b111};
    rx_phy1 = {48'h1234_5678_9abc, 3'b000};
    next_cycle();
    next_cycle();
    // First payload bit of channel 0 is the flit valid bit
    check_value("ustrm_valid", rx_phy0[PAYLOAD_POS], ustrm_valid);
    rx_online = 1'b0;
    next_cycle();
    next_cycle();
    compare_upstream('0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    seed           = 32'hd5af;
    errors         = 0;
    loopback_en    = 1'b0;
    rst            = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    rx_phy0        = '0;
    rx_phy1        = '0;
    m_gen2_mode    = 1'b1;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    delay_x_value  = '0;
    delay_y_value  = '0;
    delay_z_value  = '0;
    apply_fields('0);
    repeat (10) next_cycle();
    rst = 1'b0;

    test_reset_idle();
    test_sync_delays();
    test_loopback_gen2();
    test_gen1_crc();
    test_userbits_count();
    test_offline();

    $display("Tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/lpif_pkg.sv
hw/lpif_link_if.sv
hw/lpif_auto_sync.sv
hw/lpif_flit_pack.sv
hw/lpif_phy_concat.sv
hw/lpif_link_top.sv
tb/lpif_link_chk.sv
tb/tb_lpif_link.sv
